// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_lvds_video_rx
FILELIST  = lvds_video_rx.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES   = $(shell grep -v '^+' $(FILELIST)) bench/tb_checks.svh
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Result: FAIL (no final report)"; exit 1; \
	else \
		echo "Result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Error counters, one per kind of result
int err_pixel = 0;
int err_sync  = 0;
int err_link  = 0;
int err_other = 0;

task automatic check_pixel(input string name, input lvds_word_pkg::pixel_t exp_val,
                           input lvds_word_pkg::pixel_t act_val);
    if (act_val !== exp_val) begin
        err_pixel++;
        $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                 $time, name, exp_val, act_val);
    end
endtask

// DE, HSYNC and VSYNC levels
task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
        err_sync++;
        $display("CHECK FAILED at %0t ns: %s expected %b, got %b",
                 $time, name, exp_val, act_val);
    end
endtask

task automatic check_link(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
        err_link++;
        $display("CHECK FAILED at %0t ns: %s expected %b, got %b",
                 $time, name, exp_val, act_val);
    end
endtask

`endif

// ==== bench/tb_lvds_video_rx.sv ====
module tb_lvds_video_rx;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HOLDOFF      = 64;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;   // Inputs move this long after the rising edge
    localparam int DATA_WORDS   = 2000;
    localparam int REPEAT_WORDS = 200;
    localparam int DROP_CYCLES  = 11;  // 3 edges to fall plus idle
    localparam int SHORT_LOCK   = HOLDOFF / 2;

    localparam int STIM_CYCLES = 8 + 16 + 3 * (HOLDOFF + 4) + DATA_WORDS + 2 * REPEAT_WORDS
                                 + 3 * DROP_CYCLES + SHORT_LOCK + HOLDOFF + 8;
    localparam int WATCHDOG_NS = (STIM_CYCLES + 4 * HOLDOFF) * CLK_PERIOD;

    logic                       deser_clk;
    logic                       c3_sys_rst_i;
    logic                       i_rx_lock;
    lvds_word_pkg::deser_word_t i_deser_word;
    logic                       o_link_up;
    lvds_word_pkg::pixel_t      o_pix_a;
    lvds_word_pkg::pixel_t      o_pix_b;
    logic                       o_de;
    logic                       o_hsync;
    logic                       o_vsync;

    integer seed;

    // Reference model state, one edge behind the DUT outputs
    lvds_word_pkg::deser_word_t prev_word    = '0;
    logic                       prev_link_up = 1'b0;
    lvds_word_pkg::pixel_t      exp_pix_a;
    lvds_word_pkg::pixel_t      exp_pix_b;
    logic                       exp_de;
    logic                       exp_hsync;
    logic                       exp_vsync;
    int                         active_checks = 0;
    int                         total_errors;

    `include "tb_checks.svh"

    lvds_video_rx #(
        .HOLDOFF_CYCLES (HOLDOFF)
    ) uut (
        .deser_clk    (deser_clk),
        .c3_sys_rst_i (c3_sys_rst_i),
        .i_rx_lock    (i_rx_lock),
        .i_deser_word (i_deser_word),
        .o_link_up    (o_link_up),
        .o_pix_a      (o_pix_a),
        .o_pix_b      (o_pix_b),
        .o_de         (o_de),
        .o_hsync      (o_hsync),
        .o_vsync      (o_vsync)
    );

    initial begin
        deser_clk = 1'b0;
        forever #(CLK_PERIOD / 2) deser_clk = ~deser_clk;
    end

    // Colour bytes gathered from a channel starting at bit base
    function automatic lvds_word_pkg::pixel_t expected_pixel(
        input lvds_word_pkg::deser_word_t word,
        input int                         base
    );
        logic [7:0] blue;
        logic [7:0] green;
        logic [7:0] red;
        blue  = {word[base + 25 +: 2], word[base + 12 +: 6]};
        green = {word[base + 23 +: 2], word[base + 6 +: 6]};
        red   = {word[base + 21 +: 2], word[base +: 6]};
        return {blue, green, red};
    endfunction

    task automatic drive_random_word();
        logic [63:0] raw;
        raw = {$random(seed), $random(seed)};
        i_deser_word = raw[lvds_word_pkg::WORD_W-1:0];
    endtask

    // One clock, then a fresh word just after the edge
    task automatic next_cycle();
        @(posedge deser_clk);
        #(DRIVE_DELAY);
        drive_random_word();
    endtask

    // Lock rises, link must hold off for the whole settle time
    task automatic bring_up_link();
        int k;
        i_rx_lock = 1'b1;
        for (k = 0; k <= HOLDOFF + 3; k++) begin
            next_cycle();
            if (k < HOLDOFF) begin
                check_link("o_link_up", 1'b0, o_link_up);
            end
        end
        check_link("o_link_up", 1'b1, o_link_up); // Up at HOLDOFF+3 edges
    endtask

    task automatic drop_link();
        int k;
        i_rx_lock = 1'b0;
        for (k = 0; k < 3; k++) begin
            next_cycle();
        end
        check_link("o_link_up", 1'b0, o_link_up);
        repeat (DROP_CYCLES - 3) next_cycle();
    endtask

    // Lock that goes away before the hold-off ends
    task automatic short_lock_pulse();
        i_rx_lock = 1'b1;
        repeat (SHORT_LOCK) begin
            next_cycle();
            check_link("o_link_up", 1'b0, o_link_up);
        end
        i_rx_lock = 1'b0;
        repeat (HOLDOFF + 8) begin
            next_cycle();
            check_link("o_link_up", 1'b0, o_link_up);
        end
    endtask

    // Output monitor at the falling edge, model uses the word seen at the last rising edge
    always @(negedge deser_clk) begin
        if (c3_sys_rst_i) begin
            exp_pix_a = '0;
            exp_pix_b = '0;
            exp_de    = 1'b0;
            exp_hsync = 1'b0;
            exp_vsync = 1'b0;
            check_link("o_link_up", 1'b0, o_link_up);
        end else if (prev_link_up) begin
            exp_pix_a = expected_pixel(prev_word, 0);
            exp_pix_b = expected_pixel(prev_word, lvds_word_pkg::CH_B_OFS);
            exp_de    = ~prev_word[lvds_word_pkg::DE_BIT]; // Active low on the wire
            exp_hsync = ~prev_word[lvds_word_pkg::HS_BIT];
            exp_vsync = ~prev_word[lvds_word_pkg::VS_BIT];
            active_checks++;
        end else begin
            exp_pix_a = '0;
            exp_pix_b = '0;
            exp_de    = 1'b0;
            exp_hsync = 1'b0;
            exp_vsync = 1'b0;
        end
        check_pixel("o_pix_a", exp_pix_a, o_pix_a);
        check_pixel("o_pix_b", exp_pix_b, o_pix_b);
        check_bit("o_de", exp_de, o_de);
        check_bit("o_hsync", exp_hsync, o_hsync);
        check_bit("o_vsync", exp_vsync, o_vsync);
        prev_word    = i_deser_word;
        prev_link_up = o_link_up;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the stimulus finished", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed         = 32'h7a0dba21;
        c3_sys_rst_i = 1'b1;
        i_rx_lock    = 1'b0;
        i_deser_word = '0;

        repeat (8) @(posedge deser_clk);
        #(DRIVE_DELAY);
        c3_sys_rst_i = 1'b0;

        // Out of reset with no lock
        repeat (16) begin
            next_cycle();
            check_link("o_link_up", 1'b0, o_link_up);
        end

        bring_up_link();
        repeat (DATA_WORDS) next_cycle();
        drop_link();

        bring_up_link(); // Relock after a drop
        repeat (REPEAT_WORDS) next_cycle();
        drop_link();

        short_lock_pulse();
        bring_up_link();
        repeat (REPEAT_WORDS) next_cycle();
        drop_link();

        @(negedge deser_clk);
        #1;
        if (active_checks < DATA_WORDS + 2 * REPEAT_WORDS) begin
            err_other++;
            $display("Too few words were checked with the link up: %0d", active_checks);
        end

        total_errors = err_pixel + err_sync + err_link + err_other;
        $display("Errors: %0d (pixel %0d, sync %0d, link %0d, other %0d)",
                 total_errors, err_pixel, err_sync, err_link, err_other);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hdl/holdoff_timer.sv ====
module holdoff_timer #(
    parameter int HOLDOFF_CYCLES = 64
) (
    input  logic deser_clk,
    input  logic c3_sys_rst_i,
    input  logic i_run,
    output logic o_done
);

    localparam logic [link_ctrl_pkg::HOLDOFF_W-1:0] TERMINAL =
        link_ctrl_pkg::HOLDOFF_W'(HOLDOFF_CYCLES - 1);

    logic [link_ctrl_pkg::HOLDOFF_W-1:0] settle_cnt;

    // Saturating count, restarts from zero each time run drops
    always_ff @(posedge deser_clk or posedge c3_sys_rst_i) begin
        if (c3_sys_rst_i) begin
            settle_cnt <= '0;
        end else if (!i_run) begin
            settle_cnt <= '0;
        end else if (settle_cnt != TERMINAL) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    assign o_done = (settle_cnt == TERMINAL); // Held while run stays high

    // Counter parks at the terminal value and never runs past it
    a_cnt_bounded: assert property (
        @(posedge deser_clk) disable iff (c3_sys_rst_i)
        settle_cnt <= TERMINAL
    );

endmodule

// ==== hdl/link_ctrl_pkg.sv ====
package link_ctrl_pkg;

    // Link bring-up states
    typedef enum logic [1:0] {
        LINK_DOWN   = 2'd0, // No lock, video off
        LINK_SETTLE = 2'd1, // Lock seen, waiting out the hold-off
        LINK_UP     = 2'd2  // Video passes through
    } link_state_e;

    // Hold-off counter width, enough for 65536 settle cycles
    localparam int HOLDOFF_W = 16;

endpackage

// ==== hdl/link_state_fsm.sv ====
module link_state_fsm (
    input  logic deser_clk,
    input  logic c3_sys_rst_i,
    input  logic i_rx_lock,
    input  logic i_timer_done,
    output logic o_timer_run,
    output logic o_link_up
);

    logic lock_meta;
    logic lock_sync;

    link_ctrl_pkg::link_state_e state;
    link_ctrl_pkg::link_state_e state_nxt;

    // Lock comes from the serdes PLL, two flops before use
    always_ff @(posedge deser_clk or posedge c3_sys_rst_i) begin
        if (c3_sys_rst_i) begin
            lock_meta <= 1'b0;
            lock_sync <= 1'b0;
        end else begin
            lock_meta <= i_rx_lock;
            lock_sync <= lock_meta;
        end
    end

    always_comb begin
        state_nxt = state;
        if (!lock_sync) begin
            state_nxt = link_ctrl_pkg::LINK_DOWN; // Lock loss wins everywhere
        end else begin
            case (state)
                link_ctrl_pkg::LINK_DOWN:   state_nxt = link_ctrl_pkg::LINK_SETTLE;
                link_ctrl_pkg::LINK_SETTLE: begin
                    if (i_timer_done) begin
                        state_nxt = link_ctrl_pkg::LINK_UP;
                    end
                end
                link_ctrl_pkg::LINK_UP:     state_nxt = link_ctrl_pkg::LINK_UP;
                default:                    state_nxt = link_ctrl_pkg::LINK_DOWN;
            endcase
        end
    end

    always_ff @(posedge deser_clk or posedge c3_sys_rst_i) begin
        if (c3_sys_rst_i) begin
            state     <= link_ctrl_pkg::LINK_DOWN;
            o_link_up <= 1'b0;
        end else begin
            state     <= state_nxt;
            // Qualified by lock so a drop reaches the video one edge sooner
            o_link_up <= (state == link_ctrl_pkg::LINK_UP) && lock_sync;
        end
    end

    assign o_timer_run = (state == link_ctrl_pkg::LINK_SETTLE);

    // Every bring-up has to pass through the hold-off
    a_no_skip_settle: assert property (
        @(posedge deser_clk) disable iff (c3_sys_rst_i)
        (state == link_ctrl_pkg::LINK_DOWN) |=> (state != link_ctrl_pkg::LINK_UP)
    );

endmodule

// ==== hdl/lvds_video_rx.sv ====
module lvds_video_rx #(
    parameter int HOLDOFF_CYCLES = 64
) (
    input  logic                        deser_clk,
    input  logic                        c3_sys_rst_i,
    input  logic                        i_rx_lock,
    input  lvds_word_pkg::deser_word_t  i_deser_word,
    output logic                        o_link_up,
    output lvds_word_pkg::pixel_t       o_pix_a,
    output lvds_word_pkg::pixel_t       o_pix_b,
    output logic                        o_de,
    output logic                        o_hsync,
    output logic                        o_vsync
);

    logic timer_run;
    logic timer_done;
    logic link_up;

    // Settle counter for the hold-off after lock
    holdoff_timer #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_holdoff_timer (
        .deser_clk    (deser_clk),
        .c3_sys_rst_i (c3_sys_rst_i),
        .i_run        (timer_run),
        .o_done       (timer_done)
    );

    link_state_fsm u_link_state_fsm (
        .deser_clk    (deser_clk),
        .c3_sys_rst_i (c3_sys_rst_i),
        .i_rx_lock    (i_rx_lock),
        .i_timer_done (timer_done),
        .o_timer_run  (timer_run),
        .o_link_up    (link_up)
    );

    // Word to pixel mapping, blanked while the link is down
    pixel_unpacker u_pixel_unpacker (
        .deser_clk    (deser_clk),
        .c3_sys_rst_i (c3_sys_rst_i),
        .i_enable     (link_up),
        .i_word       (i_deser_word),
        .o_pix_a      (o_pix_a),
        .o_pix_b      (o_pix_b),
        .o_de         (o_de),
        .o_hsync      (o_hsync),
        .o_vsync      (o_vsync)
    );

    assign o_link_up = link_up;

endmodule

// ==== hdl/lvds_word_pkg.sv ====
package lvds_word_pkg;

    // One deserialized word, both channels side by side
    localparam int WORD_W = 56;

    // One RGB pixel, 8 bits per colour
    localparam int PIX_W = 24;

    typedef logic [WORD_W-1:0] deser_word_t;

    // Blue in [23:16], green in [15:8], red in [7:0]
    typedef logic [PIX_W-1:0] pixel_t;

    // Active-low control bits of the first channel
    localparam int DE_BIT = 20;
    localparam int HS_BIT = 18;
    localparam int VS_BIT = 19;

    // Second channel starts here, same layout as the first
    localparam int CH_B_OFS = 28;

endpackage

// ==== hdl/pixel_unpacker.sv ====
module pixel_unpacker (
    input  logic                        deser_clk,
    input  logic                        c3_sys_rst_i,
    input  logic                        i_enable,
    input  lvds_word_pkg::deser_word_t  i_word,
    output lvds_word_pkg::pixel_t       o_pix_a,
    output lvds_word_pkg::pixel_t       o_pix_b,
    output logic                        o_de,
    output logic                        o_hsync,
    output logic                        o_vsync
);

    // Channel slice is as wide as the offset of the second channel
    localparam int CH_W = lvds_word_pkg::CH_B_OFS;

    // Two MSBs of each colour sit on the fourth data pair
    function automatic lvds_word_pkg::pixel_t map_channel(input logic [CH_W-1:0] ch);
        lvds_word_pkg::pixel_t pix;
        pix = {ch[26:25], ch[17:12],   // Blue
               ch[24:23], ch[11:6],    // Green
               ch[22:21], ch[5:0]};    // Red
        return pix;
    endfunction

    lvds_word_pkg::pixel_t pix_a_nxt;
    lvds_word_pkg::pixel_t pix_b_nxt;

    assign pix_a_nxt = map_channel(i_word[CH_W-1:0]);
    assign pix_b_nxt = map_channel(i_word[lvds_word_pkg::CH_B_OFS +: CH_W]); // Bit 55 unused

    always_ff @(posedge deser_clk or posedge c3_sys_rst_i) begin
        if (c3_sys_rst_i) begin
            o_pix_a <= '0;
            o_pix_b <= '0;
            o_de    <= 1'b0;
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
        end else if (!i_enable) begin
            o_pix_a <= '0; // Link down, blank everything
            o_pix_b <= '0;
            o_de    <= 1'b0;
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
        end else begin
            o_pix_a <= pix_a_nxt;
            o_pix_b <= pix_b_nxt;
            // Sync levels taken from the first channel only
            o_de    <= ~i_word[lvds_word_pkg::DE_BIT];
            o_hsync <= ~i_word[lvds_word_pkg::HS_BIT];
            o_vsync <= ~i_word[lvds_word_pkg::VS_BIT];
        end
    end

    a_blank_when_off: assert property (
        @(posedge deser_clk) disable iff (c3_sys_rst_i)
        !i_enable |=> (o_pix_a == '0 && o_pix_b == '0 && !o_de && !o_hsync && !o_vsync)
    );

endmodule

// ==== lvds_video_rx.f ====
+incdir+bench
hdl/lvds_word_pkg.sv
hdl/link_ctrl_pkg.sv
hdl/holdoff_timer.sv
hdl/link_state_fsm.sv
hdl/pixel_unpacker.sv
hdl/lvds_video_rx.sv
bench/tb_lvds_video_rx.sv
